/* hdl/tcb_pkg.sv */
package tcb_pkg;

  //////////////////////////////////////////////////
  // bus sizes
  //////////////////////////////////////////////////

  // address and data width
  localparam int unsigned TCB_ADR = 32;
  localparam int unsigned TCB_DAT = 32;
  // byte width and number of byte lanes
  localparam int unsigned TCB_UNT = 8;
  localparam int unsigned TCB_BEN = TCB_DAT / TCB_UNT;
  // byte offset inside a data word
  localparam int unsigned TCB_OFF = $clog2(TCB_BEN);
  // low address bits cleared in memory mode
  localparam int unsigned TCB_ALN = 2;
  // response delay in clock cycles
  localparam int unsigned TCB_DLY = 1;
  // memory depth in words and width of the word index
  localparam int unsigned TCB_MEM_DEPTH = 64;
  localparam int unsigned TCB_MEM_AW = $clog2(TCB_MEM_DEPTH);

  //////////////////////////////////////////////////
  // request and response types
  //////////////////////////////////////////////////

  // byte order of a transfer
  typedef enum logic {
    TCB_LITTLE = 1'b0,
    TCB_BIG    = 1'b1
  } tcb_ndn_t;

  // log2 of the transfer size in bytes (0, 1 or 2)
  typedef logic [1:0] tcb_siz_t;

  // RISC-V mode, data sits in the low bytes
  typedef struct packed {
    logic               cmd;
    logic               wen;
    tcb_ndn_t           ndn;
    logic [TCB_ADR-1:0] adr;
    tcb_siz_t           siz;
    logic [TCB_DAT-1:0] wdt;
  } tcb_req_riscv_t;

  // memory mode, word aligned address with per lane enables
  typedef struct packed {
    logic               cmd;
    logic               wen;
    tcb_ndn_t           ndn;
    logic [TCB_ADR-1:0] adr;
    logic [TCB_BEN-1:0] ben;
    logic [TCB_DAT-1:0] wdt;
  } tcb_req_memory_t;

  // response, sts set means error
  typedef struct packed {
    logic [TCB_DAT-1:0] rdt;
    logic               sts;
  } tcb_rsp_t;

endpackage

/* hdl/tcb_if.sv */
`timescale 1ns/100ps

interface tcb_if #(
  // request payload, RISC-V or memory mode
  parameter type req_t = tcb_pkg::tcb_req_riscv_t
)(
  input logic clk,
  input logic reset
);

  //////////////////////////////////////////////////
  // bus signals
  //////////////////////////////////////////////////

  // handshake
  logic vld;
  logic rdy;

  // payload in both directions
  req_t              req;
  tcb_pkg::tcb_rsp_t rsp;

  //////////////////////////////////////////////////
  // delay line
  //////////////////////////////////////////////////

  // what the response stage needs to know about its request
  typedef struct packed {
    logic [tcb_pkg::TCB_OFF-1:0] off;
    tcb_pkg::tcb_ndn_t           ndn;
    logic                        vld;
  } dly_t;

  // entry 0 is the current cycle, entry TCB_DLY lines up with rsp
  dly_t dly [0:tcb_pkg::TCB_DLY];

  // current request, vld marks an actual transfer
  assign dly[0].off = req.adr[tcb_pkg::TCB_OFF-1:0];
  assign dly[0].ndn = req.ndn;
  assign dly[0].vld = vld & rdy;

  // each stage copies the one below it on every clock
  for (genvar i = 1; i <= tcb_pkg::TCB_DLY; i++) begin : gen_dly
    always_ff @(posedge clk) begin
      if (reset) begin
        dly[i].vld <= 1'b0;
      end else begin
        dly[i].vld <= dly[i-1].vld;
      end
      // offset and byte order only matter while vld is set
      dly[i].off <= dly[i-1].off;
      dly[i].ndn <= dly[i-1].ndn;
    end
  end : gen_dly

  //////////////////////////////////////////////////
  // modports
  //////////////////////////////////////////////////

  modport man (input clk, reset, output vld, req, input rdy, rsp);

  modport sub (input clk, reset, input vld, req, output rdy, rsp, input dly);

  modport mon (input clk, reset, vld, rdy, req, rsp, dly);

endinterface

/* hdl/tcb_lib_riscv2memory.sv */
`timescale 1ns/100ps

module tcb_lib_riscv2memory (
  // RISC-V mode manager connects here
  tcb_if.sub sub,
  // memory mode subordinate connects here
  tcb_if.man man
);

  //////////////////////////////////////////////////
  // local signals
  //////////////////////////////////////////////////

  // write data split into bytes, before and after rotation
  logic [tcb_pkg::TCB_BEN-1:0][tcb_pkg::TCB_UNT-1:0] sub_wdt;
  logic [tcb_pkg::TCB_BEN-1:0][tcb_pkg::TCB_UNT-1:0] man_wdt;

  // read data split into bytes, lanes first then low bytes
  logic [tcb_pkg::TCB_BEN-1:0][tcb_pkg::TCB_UNT-1:0] man_rdt;
  logic [tcb_pkg::TCB_BEN-1:0][tcb_pkg::TCB_UNT-1:0] sub_rdt;

  // byte enable per data byte and per lane
  logic [tcb_pkg::TCB_BEN-1:0] sub_ben;
  logic [tcb_pkg::TCB_BEN-1:0] man_ben;

  // byte offset of the request and of the pending response
  logic [tcb_pkg::TCB_OFF-1:0] req_off;
  logic [tcb_pkg::TCB_OFF-1:0] rsp_off;

  // byte order of the request and of the pending response
  tcb_pkg::tcb_ndn_t req_ndn;
  tcb_pkg::tcb_ndn_t rsp_ndn;

  // data byte carried on each lane
  logic [tcb_pkg::TCB_BEN-1:0][tcb_pkg::TCB_OFF-1:0] req_idx;
  // lane feeding each data byte on the way back
  logic [tcb_pkg::TCB_BEN-1:0][tcb_pkg::TCB_OFF-1:0] rsp_idx;

  // assembled memory mode request
  tcb_pkg::tcb_req_memory_t req_mem;

  // offset and order from the delay line
  assign req_off = sub.dly[0].off;
  assign req_ndn = sub.dly[0].ndn;
  // response side uses the delayed copies, not the live request
  assign rsp_off = sub.dly[tcb_pkg::TCB_DLY].off;
  assign rsp_ndn = sub.dly[tcb_pkg::TCB_DLY].ndn;

  //////////////////////////////////////////////////
  // request path
  //////////////////////////////////////////////////

  assign sub_wdt = sub.req.wdt;

  // the first 2**siz data bytes are enabled
  always_comb begin
    for (int unsigned i = 0; i < tcb_pkg::TCB_BEN; i++) begin
      sub_ben[i] = (i < (32'd1 << sub.req.siz));
    end
  end

  // little endian lane i holds byte i-off, big endian lane i holds byte off-i
  always_comb begin
    for (int unsigned i = 0; i < tcb_pkg::TCB_BEN; i++) begin
      if (req_ndn == tcb_pkg::TCB_BIG) begin
        req_idx[i] = req_off - i[tcb_pkg::TCB_OFF-1:0];
      end else begin
        req_idx[i] = i[tcb_pkg::TCB_OFF-1:0] - req_off;
      end
      man_ben[i] = sub_ben[req_idx[i]];
      man_wdt[i] = sub_wdt[req_idx[i]];
    end
  end

  // control passes through, address drops the low bits
  always_comb begin
    req_mem.cmd = sub.req.cmd;
    req_mem.wen = sub.req.wen;
    req_mem.ndn = sub.req.ndn;
    req_mem.adr = {sub.req.adr[tcb_pkg::TCB_ADR-1:tcb_pkg::TCB_ALN],
                   {tcb_pkg::TCB_ALN{1'b0}}};
    req_mem.ben = man_ben;
    req_mem.wdt = man_wdt;
  end

  assign man.vld = sub.vld;
  assign man.req = req_mem;

  //////////////////////////////////////////////////
  // response path
  //////////////////////////////////////////////////

  assign man_rdt = man.rsp.rdt;

  // inverse of the request rotation, byte k comes from lane off+k or off-k
  always_comb begin
    for (int unsigned k = 0; k < tcb_pkg::TCB_BEN; k++) begin
      if (rsp_ndn == tcb_pkg::TCB_BIG) begin
        rsp_idx[k] = rsp_off - k[tcb_pkg::TCB_OFF-1:0];
      end else begin
        rsp_idx[k] = rsp_off + k[tcb_pkg::TCB_OFF-1:0];
      end
      sub_rdt[k] = man_rdt[rsp_idx[k]];
    end
  end

  assign sub.rsp.rdt = sub_rdt;
  // status and back-pressure are untouched
  assign sub.rsp.sts = man.rsp.sts;
  assign sub.rdy     = man.rdy;

endmodule

/* hdl/tcb_mem.sv */
`timescale 1ns/100ps

module tcb_mem (
  input logic clk,
  input logic reset,
  // memory mode subordinate
  tcb_if.sub  bus
);

  //////////////////////////////////////////////////
  // storage and decode
  //////////////////////////////////////////////////

  // word array, one byte per lane
  logic [tcb_pkg::TCB_BEN-1:0][tcb_pkg::TCB_UNT-1:0] mem [0:tcb_pkg::TCB_MEM_DEPTH-1];

  // write data in lanes
  logic [tcb_pkg::TCB_BEN-1:0][tcb_pkg::TCB_UNT-1:0] wdt;

  // word address and the part that indexes the array
  logic [tcb_pkg::TCB_ADR-tcb_pkg::TCB_ALN-1:0] wrd;
  logic [tcb_pkg::TCB_MEM_AW-1:0]               idx;
  logic                                         in_range;

  // accepted transfer
  logic trn;

  // clearing sequence after reset
  logic                           clr_run;
  logic [tcb_pkg::TCB_MEM_AW-1:0] clr_cnt;

  // registered response
  logic [tcb_pkg::TCB_DAT-1:0] rsp_rdt;
  logic                        rsp_sts;

  assign wdt = bus.req.wdt;
  assign wrd = bus.req.adr[tcb_pkg::TCB_ADR-1:tcb_pkg::TCB_ALN];
  assign idx = wrd[tcb_pkg::TCB_MEM_AW-1:0];
  // depth is a power of two, so any bit above the index means out of range
  assign in_range = (wrd[tcb_pkg::TCB_ADR-tcb_pkg::TCB_ALN-1:tcb_pkg::TCB_MEM_AW] == '0);

  assign trn = bus.vld & bus.rdy;

  //////////////////////////////////////////////////
  // clearing
  //////////////////////////////////////////////////

  // one word per cycle, rdy stays low until the last one is written
  always_ff @(posedge clk) begin
    if (reset) begin
      clr_run <= 1'b1;
      clr_cnt <= '0;
    end else if (clr_run) begin
      clr_cnt <= clr_cnt + 1'b1;
      if (&clr_cnt) begin
        clr_run <= 1'b0;
      end
    end
  end

  assign bus.rdy = ~clr_run;

  //////////////////////////////////////////////////
  // access
  //////////////////////////////////////////////////

  // write enabled lanes only, the clear takes priority
  always_ff @(posedge clk) begin
    if (clr_run) begin
      mem[clr_cnt] <= '0;
    end else if (trn && bus.req.wen && in_range) begin
      for (int unsigned i = 0; i < tcb_pkg::TCB_BEN; i++) begin
        if (bus.req.ben[i]) begin
          mem[idx][i] <= wdt[i];
        end
      end
    end
  end

  // read latency of one cycle, bad address answers with error and zero data
  always_ff @(posedge clk) begin
    if (trn) begin
      if (!in_range) begin
        rsp_rdt <= '0;
        rsp_sts <= 1'b1;
      end else begin
        rsp_sts <= 1'b0;
        if (!bus.req.wen) begin
          rsp_rdt <= mem[idx];
        end
      end
    end
  end

  assign bus.rsp.rdt = rsp_rdt;
  assign bus.rsp.sts = rsp_sts;

endmodule

/* hdl/tcb_subsystem.sv */
`timescale 1ns/100ps

module tcb_subsystem (
  input  logic                        clk,
  input  logic                        reset,
  // request handshake and control
  input  logic                        vld,
  input  logic                        wen,
  input  logic                        ndn,
  input  tcb_pkg::tcb_siz_t           siz,
  // byte address and write data in the low bytes
  input  logic [tcb_pkg::TCB_ADR-1:0] adr,
  input  logic [tcb_pkg::TCB_DAT-1:0] wdt,
  // back-pressure
  output logic                        rdy,
  // response, one cycle after the transfer
  output logic                        rsp_vld,
  output logic [tcb_pkg::TCB_DAT-1:0] rdt,
  output logic                        sts
);

  //////////////////////////////////////////////////
  // bus instances
  //////////////////////////////////////////////////

  // RISC-V mode side, driven from the ports
  tcb_if #(
    .req_t (tcb_pkg::tcb_req_riscv_t)
  ) tcb_riscv (
    .clk   (clk),
    .reset (reset)
  );

  // memory mode side, between converter and memory
  tcb_if #(
    .req_t (tcb_pkg::tcb_req_memory_t)
  ) tcb_memory (
    .clk   (clk),
    .reset (reset)
  );

  // ports onto the RISC-V request, cmd is always zero here
  assign tcb_riscv.vld = vld;
  assign tcb_riscv.req = '{cmd: 1'b0,
                           wen: wen,
                           ndn: tcb_pkg::tcb_ndn_t'(ndn),
                           adr: adr,
                           siz: siz,
                           wdt: wdt};

  // response side back to the ports
  assign rdy     = tcb_riscv.rdy;
  assign rsp_vld = tcb_riscv.dly[tcb_pkg::TCB_DLY].vld;
  assign rdt     = tcb_riscv.rsp.rdt;
  assign sts     = tcb_riscv.rsp.sts;

  //////////////////////////////////////////////////
  // converter and memory
  //////////////////////////////////////////////////

  tcb_lib_riscv2memory riscv2memory_i (
    .sub (tcb_riscv),
    .man (tcb_memory)
  );

  tcb_mem mem_i (
    .clk   (clk),
    .reset (reset),
    .bus   (tcb_memory)
  );

endmodule

/* verification/tcb_subsystem_asserts.sv */
`timescale 1ns/100ps

module tcb_subsystem_asserts (
  input logic                    clk,
  input logic                    reset,
  // top level handshake and response marker
  input logic                    vld,
  input logic                    rdy,
  input logic                    rsp_vld,
  // internal RISC-V mode bus
  input logic                    riscv_vld,
  input logic                    riscv_rdy,
  input tcb_pkg::tcb_req_riscv_t riscv_req
);

  // failed assertions so far
  int unsigned fail_cnt = 0;

  // cycles spent clearing since reset fell
  int unsigned clr_wait;

  always_ff @(posedge clk) begin
    if (reset) begin
      clr_wait <= 0;
    end else if (!rdy) begin
      clr_wait <= clr_wait + 1;
    end
  end

  //////////////////////////////////////////////////
  // reset and clearing
  //////////////////////////////////////////////////

  // bus stays quiet while reset is held
  a_reset_quiet: assert property (@(posedge clk) reset && $past(reset) |-> !rdy && !rsp_vld)
    else begin
      $error("rdy or rsp_vld high during reset");
      fail_cnt++;
    end

  // clear finishes within the memory depth plus a little slack
  a_clear_time: assert property (@(posedge clk) clr_wait <= tcb_pkg::TCB_MEM_DEPTH + 2)
    else begin
      $error("rdy did not rise after clearing");
      fail_cnt++;
    end

  // once ready, always ready
  a_rdy_hold: assert property (@(posedge clk) disable iff (reset) $past(rdy) |-> rdy)
    else begin
      $error("rdy fell after clearing");
      fail_cnt++;
    end

  //////////////////////////////////////////////////
  // handshake
  //////////////////////////////////////////////////

  // response exactly one cycle after each transfer
  a_rsp_timing: assert property (@(posedge clk) disable iff (reset)
                                 rsp_vld == $past(vld && rdy))
    else begin
      $error("rsp_vld does not follow the transfer by one cycle");
      fail_cnt++;
    end

  // stalled request is held unchanged
  a_req_stable: assert property (@(posedge clk) disable iff (reset)
                                 riscv_vld && !riscv_rdy |=> riscv_vld && $stable(riscv_req))
    else begin
      $error("request changed while waiting for rdy");
      fail_cnt++;
    end

endmodule

/* verification/tcb_subsystem_tb.sv */
`timescale 1ns/100ps

module tcb_subsystem_tb;

  //////////////////////////////////////////////////
  // DUT signals and model state
  //////////////////////////////////////////////////

  logic                        clk;
  logic                        reset;
  logic                        vld;
  logic                        wen;
  logic                        ndn;
  tcb_pkg::tcb_siz_t           siz;
  logic [tcb_pkg::TCB_ADR-1:0] adr;
  logic [tcb_pkg::TCB_DAT-1:0] wdt;
  logic                        rdy;
  logic                        rsp_vld;
  logic [tcb_pkg::TCB_DAT-1:0] rdt;
  logic                        sts;

  // expected memory with one byte per entry at word*4+lane
  logic [7:0]  shadow [0:tcb_pkg::TCB_MEM_DEPTH*tcb_pkg::TCB_BEN-1];
  logic [31:0] rng_state;
  int unsigned errors;
  int unsigned checks;

  tcb_subsystem tcb_subsystem_i (
    .clk     (clk),
    .reset   (reset),
    .vld     (vld),
    .wen     (wen),
    .ndn     (ndn),
    .siz     (siz),
    .adr     (adr),
    .wdt     (wdt),
    .rdy     (rdy),
    .rsp_vld (rsp_vld),
    .rdt     (rdt),
    .sts     (sts)
  );

  // protocol checks on the top ports and the RISC-V side bus
  bind tcb_subsystem tcb_subsystem_asserts asserts_i (
    .clk       (clk),
    .reset     (reset),
    .vld       (vld),
    .rdy       (rdy),
    .rsp_vld   (rsp_vld),
    .riscv_vld (tcb_riscv.vld),
    .riscv_rdy (tcb_riscv.rdy),
    .riscv_req (tcb_riscv.req)
  );

  always #10 clk = ~clk;

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  function automatic logic [31:0] next_random();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  // lane carrying data byte k where big endian counts down from the offset
  function automatic int unsigned lane_of(logic big, int unsigned off, int unsigned k);
    if (big) begin
      return (off - k) & (tcb_pkg::TCB_BEN - 1);
    end
    return (off + k) & (tcb_pkg::TCB_BEN - 1);
  endfunction

  // closing count and verdict
  task automatic finish_run();
    int unsigned fails;
    fails = tcb_subsystem_i.asserts_i.fail_cnt;
    $display("checks %0d, testbench errors %0d, assertion failures %0d", checks, errors, fails);
    if (errors + fails == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  endtask

  task automatic idle(int unsigned n);
    vld = 1'b0;
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  // one transfer with its response checked in the cycle after it
  task automatic access(input string name, input logic w, input logic n,
                        input tcb_pkg::tcb_siz_t s, input logic [31:0] a,
                        input logic [31:0] d);
    logic [31:0] exp_rdt;
    logic        exp_sts;
    int unsigned wrd;
    int unsigned off;
    int unsigned cnt;
    wrd = a >> 2;
    off = a & 32'd3;
    exp_sts = (wrd >= tcb_pkg::TCB_MEM_DEPTH);
    exp_rdt = '0;
    // read data is the whole word rotated by the lane rule
    if (!exp_sts) begin
      for (int unsigned k = 0; k < tcb_pkg::TCB_BEN; k++) begin
        exp_rdt[8*k +: 8] = shadow[wrd*4 + lane_of(n, off, k)];
      end
    end
    vld = 1'b1;
    wen = w;
    ndn = n;
    siz = s;
    adr = a;
    wdt = d;
    // held while clearing
    cnt = 0;
    while (!rdy) begin
      @(posedge clk);
      #1;
      cnt++;
      if (cnt > tcb_pkg::TCB_MEM_DEPTH + 8) begin
        $display("timeout in test %s, rdy never went high", name);
        errors++;
        finish_run();
      end
    end
    @(posedge clk);
    #1;
    vld = 1'b0;
    cnt = 0;
    while (!rsp_vld) begin
      @(posedge clk);
      #1;
      cnt++;
      if (cnt > 4) begin
        $display("timeout in test %s, no response after the transfer", name);
        errors++;
        finish_run();
      end
    end
    checks++;
    assert (sts === exp_sts) else begin
      $display("Error %s: sts expected %0b, actual %0b", name, exp_sts, sts);
      errors++;
    end
    // in range writes leave rdt undefined
    if (!w || exp_sts) begin
      checks++;
      assert (rdt === exp_rdt) else begin
        $display("Error %s: rdt expected %h, actual %h", name, exp_rdt, rdt);
        errors++;
      end
    end
    if (w && !exp_sts) begin
      for (int unsigned k = 0; k < (32'd1 << s); k++) begin
        shadow[wrd*4 + lane_of(n, off, k)] = d[8*k +: 8];
      end
    end
  endtask

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  initial begin
    logic [31:0]       r;
    logic [31:0]       a;
    logic [31:0]       d;
    tcb_pkg::tcb_siz_t s;
    clk = 1'b0;
    reset = 1'b1;
    vld = 1'b0;
    wen = 1'b0;
    ndn = 1'b0;
    siz = 2'd0;
    adr = '0;
    wdt = '0;
    rng_state = 32'h4e42f381;
    errors = 0;
    checks = 0;
    for (int i = 0; i < tcb_pkg::TCB_MEM_DEPTH * tcb_pkg::TCB_BEN; i++) begin
      shadow[i] = 8'h00;
    end
    // bus must stay quiet through reset
    repeat (5) begin
      @(posedge clk);
      #1;
      checks++;
      assert (!rdy && !rsp_vld) else begin
        $display("rdy or rsp_vld went high while reset was held");
        errors++;
      end
    end
    reset = 1'b0;
    // first read goes out while the memory is still clearing
    for (int w = 0; w < tcb_pkg::TCB_MEM_DEPTH; w++) begin
      access("clear", 1'b0, 1'b0, 2'd2, 32'(w) << 2, '0);
    end
    idle(2);
    // every size at every offset in both byte orders
    for (int e = 0; e < 2; e++) begin
      for (int z = 0; z < 3; z++) begin
        for (int o = 0; o < 4; o++) begin
          r = next_random();
          a = {24'd0, r[31:26], 2'(o)};
          d = next_random();
          access(e ? "big" : "little", 1'b1, 1'(e), 2'(z), a, d);
          access(e ? "big" : "little", 1'b0, 1'(e), 2'(z), a, '0);
        end
      end
    end
    idle(1);
    // written in one byte order and read in the other
    for (int o = 0; o < 4; o++) begin
      r = next_random();
      a = {24'd0, r[31:26], 2'(o)};
      access("cross", 1'b1, 1'b0, 2'd2, a, next_random());
      access("cross", 1'b0, 1'b1, 2'd2, a, '0);
      access("cross", 1'b1, 1'b1, 2'd1, a, next_random());
      access("cross", 1'b0, 1'b0, 2'd2, a, '0);
    end
    // mixed traffic mostly back to back with a few gaps
    for (int i = 0; i < 300; i++) begin
      r = next_random();
      s = (r[29:28] == 2'd3) ? 2'd2 : r[29:28];
      a = {24'd0, r[27:22], r[21:20]};
      // now and then a word past the end
      if (r[19:16] == 4'd0) begin
        a[8] = 1'b1;
      end
      access("random", r[31], r[30], s, a, next_random());
      if (r[15:13] == 3'd0) begin
        idle(1);
      end
    end
    idle(1);
    // out of range words alias the low index bits, which must stay intact
    for (int i = 0; i < 8; i++) begin
      r = next_random();
      a = {24'd0, r[31:26], 2'b00};
      access("range", 1'b1, r[25], 2'd2, a | 32'h100, next_random());
      access("range", 1'b0, 1'b0, 2'd2, a | 32'h100, '0);
      access("range", 1'b0, 1'b0, 2'd2, a, '0);
    end
    access("range", 1'b1, 1'b0, 2'd2, 32'hffff_fffc, 32'hdead_beef);
    access("range", 1'b0, 1'b1, 2'd0, 32'hffff_ffff, '0);
    // final sweep of the whole memory against the model
    for (int w = 0; w < tcb_pkg::TCB_MEM_DEPTH; w++) begin
      access("final", 1'b0, 1'b1, 2'd2, (32'(w) << 2) | 32'd3, '0);
    end
    idle(3);
    finish_run();
  end

endmodule

/* sources.f */
hdl/tcb_pkg.sv
hdl/tcb_if.sv
hdl/tcb_lib_riscv2memory.sv
hdl/tcb_mem.sv
hdl/tcb_subsystem.sv
verification/tcb_subsystem_asserts.sv
verification/tcb_subsystem_tb.sv

/* Makefile */
# simulator, options, top module and file list
SIM       = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = tcb_subsystem_tb
FILELIST  = sources.f
BUILD_DIR = obj_dir
LOG       = sim.log
RUN_FLAGS = +verilator+error+limit+1000
PASS_MSG  = PASS: all tests

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove build output and the log"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
